//--- testbench/dct_col_golden.txt
// x[0..15] as 11-bit hex, block_flag, then X[0..15] as 12-bit hex
// zero, flat, impulse at x[0], impulse at x[15], full-scale flat
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 0 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
064 064 064 064 064 064 064 064 064 064 064 064 064 064 064 064 0 320 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
064 064 064 064 064 064 064 064 064 064 064 064 064 064 064 064 1 0c8 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
79c 79c 79c 79c 79c 79c 79c 79c 79c 79c 79c 79c 79c 79c 79c 79c 0 ce0 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
79c 79c 79c 79c 79c 79c 79c 79c 79c 79c 79c 79c 79c 79c 79c 79c 1 f38 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
040 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 0 020 02d 02c 02b 02a 028 026 023 020 01d 019 015 011 00d 009 004
040 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 1 008 02d 02c 02b 02a 028 026 023 020 01d 019 015 011 00d 009 004
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 040 0 020 fd3 02c fd5 02a fd8 026 fdd 020 fe3 019 feb 011 ff3 009 ffc
3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 0 7ff 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 3ff 1 7fe 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
400 400 400 400 400 400 400 400 400 400 400 400 400 400 400 400 0 800 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000

//--- build.f
hw/dct_pkg.sv
hw/dct_butterfly.sv
hw/dct_lane.sv
hw/dct_round.sv
hw/dct_col_top.sv
testbench/dct_col_chk.sv
testbench/tb_dct_col.sv

//--- Bender.yml
package:
  name: dct_col

sources:
  - hw/dct_pkg.sv
  - hw/dct_butterfly.sv
  - hw/dct_lane.sv
  - hw/dct_round.sv
  - hw/dct_col_top.sv
  - target: test
    files:
      - testbench/dct_col_chk.sv
      - testbench/tb_dct_col.sv

//--- testbench/tb_dct_col.sv
// DCT column testbench

`timescale 1ns/1ns

module tb_dct_col;

    import dct_pkg::*;

    // golden file layout, 33 words per column
    localparam int GOLD_COLS  = 11;
    localparam int GOLD_WORDS = 2 * N_POINTS + 1;
    localparam int N_CONST    = 8;
    localparam int N_SAT      = 8;
    localparam int N_RANDOM   = 200;
    localparam int N_ISSUE    = GOLD_COLS + N_CONST + N_SAT + N_RANDOM;
    localparam int MAX_CYCLES = (N_ISSUE + PIPE_LAT) * 4 + 200;
    localparam int CONST_VALS [0:3] = '{37, -1, 1000, -777};
    // cos(i*pi/32) scaled to 32 at i=8, index 16 is the zero crossing
    localparam int COS_TAB [0:16] = '{64, 45, 44, 43, 42, 40, 38, 35, 32,
                                      29, 25, 21, 17, 13, 9, 4, 0};

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    logic        block_flag;
    sample_col_t x_in;
    logic        out_valid;
    coef_col_t   x_k_out;

    logic [11:0] gold_mem [0:GOLD_COLS*GOLD_WORDS-1];
    coef_col_t   exp_q[$];
    int          issue_q[$];
    int          cycle = 0;
    int          errors = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    int          mark;
    logic [31:0] lcg_state;

    dct_col_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // watchdog
    initial begin
        while (cycle < MAX_CYCLES) @(posedge clk);
        $display("timeout: no finish after %0d cycles", MAX_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // coefficient by quadrant of the angle (2p+1)k*pi/32
    function automatic int coef_ref(input int k, input int p);
        int m;
        m = ((2 * p + 1) * k) % 64;
        if (k == 0) return 32;
        if (m <= 16) return COS_TAB[m];
        if (m <= 32) return -COS_TAB[32 - m];
        if (m <= 48) return -COS_TAB[m - 32];
        return COS_TAB[64 - m];
    endfunction

    // reference column: butterfly, dot product, shift, clamp
    function automatic coef_col_t model_col(input sample_col_t col, input logic flag);
        coef_col_t res;
        longint    acc;
        longint    a;
        longint    b;
        for (int k = 0; k < N_POINTS; k++) begin
            acc = 0;
            for (int p = 0; p < N_PAIRS; p++) begin
                a = longint'(signed'(col.s[p]));
                b = longint'(signed'(col.s[N_POINTS-1-p]));
                acc += ((k % 2) ? (a - b) : (a + b)) * coef_ref(k, p);
            end
            acc = acc >>> ((k == 0 && flag) ? DC_BLOCK_SHIFT : OUT_SHIFT);
            if (acc > 2047) acc = 2047;
            if (acc < -2048) acc = -2048;
            res.row[k] = coef_t'(acc);
        end
        return res;
    endfunction

    // one column on the next falling edge, expectation queued with its cycle
    task automatic drive_col(input sample_col_t col, input logic flag, input coef_col_t exp_col);
        @(negedge clk);
        in_valid   = 1'b1;
        block_flag = flag;
        x_in       = col;
        exp_q.push_back(exp_col);
        issue_q.push_back(cycle);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        idle_cycles(1);
        while (exp_q.size() != 0) @(negedge clk);
        if (errors == errs_before) begin
            n_pass++;
            $display("test %s: ok", name);
        end else begin
            n_fail++;
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    // compare each column while outputs are steady
    always @(negedge clk) begin : monitor
        coef_col_t exp_col;
        int        exp_cyc;
        if (arst_n && out_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("output column at %0t with no column pending", $time);
                errors++;
            end
            if (exp_q.size() != 0) begin
                exp_col = exp_q.pop_front();
                exp_cyc = issue_q.pop_front() + PIPE_LAT;
                assert (cycle == exp_cyc) else begin
                    $display("ERROR %0t: column at cycle %0d, expected %0d",
                             $time, cycle, exp_cyc);
                    errors++;
                end
                for (int k = 0; k < N_POINTS; k++) begin
                    assert (x_k_out.row[k] === exp_col.row[k]) else begin
                        $display("ERROR %0t: row %0d expected %0d got %0d",
                                 $time, k, exp_col.row[k], x_k_out.row[k]);
                        errors++;
                    end
                end
            end
        end
    end

    initial begin : main
        sample_col_t col;
        coef_col_t   exp_col;
        logic [31:0] r;
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        block_flag = 1'b0;
        x_in       = '0;
        lcg_state  = 32'd23;
        $readmemh("testbench/dct_col_golden.txt", gold_mem);

        // reset, output must stay quiet
        mark = errors;
        repeat (10) begin
            @(negedge clk);
            assert (out_valid === 1'b0) else begin
                $display("ERROR %0t: out_valid high during reset", $time);
                errors++;
            end
            // output column register clears with the reset
            assert (x_k_out === '0) else begin
                $display("ERROR %0t: x_k_out not zero during reset", $time);
                errors++;
            end
        end
        arst_n = 1'b1;
        idle_cycles(4);
        end_test("reset", mark);

        // golden columns straight from the file
        mark = errors;
        for (int g = 0; g < GOLD_COLS; g++) begin
            for (int n = 0; n < N_POINTS; n++)
                col.s[n] = sample_t'(gold_mem[g*GOLD_WORDS+n]);
            for (int k = 0; k < N_POINTS; k++)
                exp_col.row[k] = coef_t'(gold_mem[g*GOLD_WORDS+N_POINTS+1+k]);
            drive_col(col, gold_mem[g*GOLD_WORDS+N_POINTS][0], exp_col);
        end
        end_test("golden", mark);

        // flat columns, both dc scalings
        mark = errors;
        for (int i = 0; i < N_CONST; i++) begin
            for (int n = 0; n < N_POINTS; n++) col.s[n] = sample_t'(CONST_VALS[i/2]);
            drive_col(col, (i % 2) == 1, model_col(col, (i % 2) == 1));
        end
        end_test("constant", mark);

        // full-scale alternating and split columns
        mark = errors;
        for (int i = 0; i < N_SAT; i++) begin
            for (int n = 0; n < N_POINTS; n++) begin
                case (i / 2)
                    0:       col.s[n] = (n % 2 == 0) ? sample_t'(1023) : sample_t'(-1024);
                    1:       col.s[n] = (n % 2 == 0) ? sample_t'(-1024) : sample_t'(1023);
                    2:       col.s[n] = sample_t'(1023);
                    default: col.s[n] = (n < 8) ? sample_t'(1023) : sample_t'(-1024);
                endcase
            end
            drive_col(col, (i % 2) == 1, model_col(col, (i % 2) == 1));
        end
        end_test("saturation", mark);

        // random columns with random gaps
        mark = errors;
        for (int i = 0; i < N_RANDOM; i++) begin
            r = lcg_next();
            idle_cycles(r[31:30]);
            for (int n = 0; n < N_POINTS; n++) col.s[n] = sample_t'(lcg_next() >> 21);
            drive_col(col, r[29], model_col(col, r[29]));
        end
        end_test("streaming", mark);

        if (UUT.u_chk.fail_count != 0) begin
            $display("bound checker saw %0d assertion failures", UUT.u_chk.fail_count);
            n_fail++;
        end
        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- testbench/dct_col_chk.sv
// DCT column timing checker

`timescale 1ns/1ns

module dct_col_chk (
    input logic               clk,
    input logic               arst_n,
    input logic               in_valid,
    input logic               out_valid,
    input dct_pkg::coef_col_t x_k_out
);

    import dct_pkg::*;

    // read back by the testbench at the end of the run
    int fail_count = 0;

    // no output strobe while held in reset
    a_quiet_in_reset: assert property (@(posedge clk) !arst_n |-> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high while reset is asserted");
        end

    // fixed three-stage latency, one out per one in
    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == $past(in_valid, PIPE_LAT))
        else begin
            fail_count++;
            $error("out_valid does not follow in_valid by the pipeline latency");
        end

    // presented data must be fully driven
    a_known_data: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> !$isunknown(x_k_out))
        else begin
            fail_count++;
            $error("x_k_out has unknown bits while out_valid is high");
        end

endmodule

bind dct_col_top dct_col_chk u_chk (.*);

//--- hw/dct_col_top.sv
// 16-point DCT column top level

`timescale 1ns/1ns

module dct_col_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_valid,
    input  logic                block_flag,
    input  dct_pkg::sample_col_t x_in,
    output logic                out_valid,
    output dct_pkg::coef_col_t  x_k_out
);

    import dct_pkg::*;

    // butterfly stage outputs
    bfly_col_t bfly_q;
    logic      bfly_valid;

    // lane stage outputs, one valid per lane
    acc_col_t              acc_q;
    logic [N_POINTS-1:0]   lane_valid;

    // block_flag aligned with the lane results
    logic block_flag_d;

    // stage 1: sums and differences of mirrored samples
    dct_butterfly u_butterfly (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .block_flag (block_flag),
        .x_in       (x_in),
        .bfly_valid (bfly_valid),
        .bfly_q     (bfly_q)
    );

    // stage 2: one dot product per output row
    for (genvar k = 0; k < N_POINTS; k++) begin : g_lane
        dct_lane #(
            .ROW (k)
        ) u_lane (
            .clk        (clk),
            .arst_n     (arst_n),
            .bfly_valid (bfly_valid),
            .bfly_q     (bfly_q),
            .acc_valid  (lane_valid[k]),
            .acc_q      (acc_q.row[k])
        );
    end

    // lanes drop the flag, so carry it across the lane stage here
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            block_flag_d <= 1'b0;
        end else if (bfly_valid) begin
            block_flag_d <= bfly_q.block_flag;
        end
    end

    // stage 3: shift, dc scaling, saturate
    // all lanes run in lockstep, lane 0 stands for the stage
    dct_round u_round (
        .clk          (clk),
        .arst_n       (arst_n),
        .acc_valid    (lane_valid[0]),
        .block_flag_d (block_flag_d),
        .acc_in       (acc_q),
        .out_valid    (out_valid),
        .x_k_out      (x_k_out)
    );

endmodule

//--- hw/dct_round.sv
// DCT output rounding and saturation

`timescale 1ns/1ns

module dct_round (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                acc_valid,
    input  logic                block_flag_d,
    input  dct_pkg::acc_col_t   acc_in,
    output logic                out_valid,
    output dct_pkg::coef_col_t  x_k_out
);

    import dct_pkg::*;

    // 12-bit output range, held at accumulator width for the compare
    localparam acc_t COEF_MAX = acc_t'((2 ** (COEF_W - 1)) - 1);
    localparam acc_t COEF_MIN = -acc_t'(2 ** (COEF_W - 1));

    coef_col_t sat_col;

    // clamp a scaled row into the output range
    function automatic coef_t saturate(input acc_t val);
        if (val > COEF_MAX) begin
            return coef_t'(COEF_MAX);
        end
        if (val < COEF_MIN) begin
            return coef_t'(COEF_MIN);
        end
        return coef_t'(val);
    endfunction

    always_comb begin
        acc_t shifted;
        for (int k = 0; k < N_POINTS; k++) begin
            // dc row has two scalings, block mode drops two more bits
            if (k == 0 && block_flag_d) begin
                shifted = acc_in.row[k] >>> DC_BLOCK_SHIFT;
            end else begin
                shifted = acc_in.row[k] >>> OUT_SHIFT;
            end
            // arithmetic shift keeps the sign, then every row clamps
            sat_col.row[k] = saturate(shifted);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= acc_valid;
        end
    end

    // output column register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            x_k_out <= '0;
        end else if (acc_valid) begin
            x_k_out <= sat_col;
        end
    end

endmodule

//--- hw/dct_lane.sv
// DCT row lane

`timescale 1ns/1ns

module dct_lane #(
    parameter int ROW = 0
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               bfly_valid,
    input  dct_pkg::bfly_col_t bfly_q,
    output logic               acc_valid,
    output dct_pkg::acc_t      acc_q
);

    import dct_pkg::*;

    // even rows see the symmetric part, odd rows the antisymmetric part
    localparam bit ODD_ROW = (ROW % 2) != 0;

    acc_t dot;

    // eight constant multiplies, recoding left to synthesis
    always_comb begin
        acc_t term;
        acc_t coef;
        dot = '0;
        for (int p = 0; p < N_PAIRS; p++) begin
            // pick the butterfly output this row needs
            term = ODD_ROW ? acc_t'(bfly_q.diff[p]) : acc_t'(bfly_q.sum[p]);
            // row 0 gives 32 on every pair
            coef = acc_t'(cos_coef(ROW, p));
            dot  = dot + term * coef;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= bfly_valid;
        end
    end

    // hold the last result between columns
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_q <= '0;
        end else if (bfly_valid) begin
            acc_q <= dot;
        end
    end

endmodule

//--- hw/dct_butterfly.sv
// DCT input butterfly

`timescale 1ns/1ns

module dct_butterfly (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_valid,
    input  logic                block_flag,
    input  dct_pkg::sample_col_t x_in,
    output logic                bfly_valid,
    output dct_pkg::bfly_col_t  bfly_q
);

    import dct_pkg::*;

    bfly_col_t bfly_d;

    // pair sample n with its mirror 15-n
    always_comb begin
        for (int p = 0; p < N_PAIRS; p++) begin
            // sign-extend to 12 bits before adding so nothing wraps
            bfly_d.sum[p]  = bfly_t'(x_in.s[p]) + bfly_t'(x_in.s[N_POINTS-1-p]);
            bfly_d.diff[p] = bfly_t'(x_in.s[p]) - bfly_t'(x_in.s[N_POINTS-1-p]);
        end
        // flag rides along with its column
        bfly_d.block_flag = block_flag;
    end

    // valid strobe, one cycle behind the input
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bfly_valid <= 1'b0;
        end else begin
            bfly_valid <= in_valid;
        end
    end

    // column register, only loads on an accepted column
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bfly_q <= '0;
        end else if (in_valid) begin
            bfly_q <= bfly_d;
        end
    end

endmodule

//--- hw/dct_pkg.sv
// 16-point DCT column package

package dct_pkg;

    // transform geometry
    localparam int N_POINTS = 16;
    localparam int N_PAIRS  = 8;

    // datapath widths
    localparam int SAMPLE_W = 11;
    localparam int BFLY_W   = 12;
    localparam int COS_W    = 8;
    localparam int ACC_W    = 22;
    localparam int COEF_W   = 12;

    // output scaling, row 0 takes the larger shift in block mode
    localparam int OUT_SHIFT      = 6;
    localparam int DC_BLOCK_SHIFT = 8;

    // butterfly + lane + round, one cycle each
    localparam int PIPE_LAT = 3;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [BFLY_W-1:0]   bfly_t;
    typedef logic signed [COS_W-1:0]    cos_t;
    typedef logic signed [ACC_W-1:0]    acc_t;
    typedef logic signed [COEF_W-1:0]   coef_t;

    // sample 0 sits in the top bits
    typedef struct packed {
        sample_t [0:N_POINTS-1] s;
    } sample_col_t;

    // sum[p] = x[p] + x[15-p], diff[p] = x[p] - x[15-p]
    typedef struct packed {
        bfly_t [0:N_PAIRS-1] sum;
        bfly_t [0:N_PAIRS-1] diff;
        logic                block_flag;
    } bfly_col_t;

    typedef struct packed {
        acc_t [0:N_POINTS-1] row;
    } acc_col_t;

    typedef struct packed {
        coef_t [0:N_POINTS-1] row;
    } coef_col_t;

    // cos(i*pi/32) scaled so that index 8 gives 32
    function automatic cos_t cos_base(input int idx);
        case (idx)
            1:       return cos_t'(45);
            2:       return cos_t'(44);
            3:       return cos_t'(43);
            4:       return cos_t'(42);
            5:       return cos_t'(40);
            6:       return cos_t'(38);
            7:       return cos_t'(35);
            8:       return cos_t'(32);
            9:       return cos_t'(29);
            10:      return cos_t'(25);
            11:      return cos_t'(21);
            12:      return cos_t'(17);
            13:      return cos_t'(13);
            14:      return cos_t'(9);
            15:      return cos_t'(4);
            // index 16 is cos(pi/2)
            default: return cos_t'(0);
        endcase
    endfunction

    // coefficient of row k applied to butterfly pair p
    function automatic cos_t cos_coef(input int k, input int p);
        int m;
        m = ((2 * p + 1) * k) % 64;
        // dc row is flat
        if (k == 0) begin
            return cos_t'(32);
        end
        // fold upper half onto 0..32
        if (m > 32) begin
            m = 64 - m;
        end
        // second quadrant is negative and mirrored around 16
        if (m > 16) begin
            return -cos_base(32 - m);
        end
        return cos_base(m);
    endfunction

endpackage
